/* project.f */
source/fetch_pkg.sv
source/uop_pkg.sv
source/inst_fetch.sv
source/fetch_buffer.sv
source/inst_decode.sv
source/core_frontend.sv
test/core_frontend_asserts.sv
test/core_frontend_tb.sv

/* test/core_frontend_tb.sv */
// ----------------------------------------------------------
// core front end testbench
// icache model, random stall, reference decoder and compare
// ----------------------------------------------------------

module core_frontend_tb;

  import fetch_pkg::*;
  import uop_pkg::*;

  localparam addr_t reset_pc    = 32'h8000_0000;
  localparam int    fb_depth    = 4;
  localparam int    mem_lines   = 64;
  localparam int    total_lines = 116;
  // up to 12 cycles of 4 units per line
  localparam int    watchdog_time = total_lines * 12 * 4 + 400;
  localparam opcode_t legal_opcodes [9] = '{OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM,
                                            OPC_LUI, OPC_AUIPC, OPC_BRANCH, OPC_JAL, OPC_JALR};

  logic                   clock;
  logic                   reset;
  logic [line_width-1:0]  icache2core_data;
  logic                   icache2core_data_valid;
  addr_t                  core2icache_addr;
  logic                   backend_stall;
  uop_group_t             uops;
  logic [fetch_width-1:0] uops_valid;

  logic [line_width-1:0] line_mem [mem_lines];
  micro_op_t             expect_q [$];
  int unsigned           next_line;
  int unsigned           line_limit;
  logic                  gap_mode;
  logic                  stall_mode;
  int unsigned           value_errors;
  int unsigned           stream_errors;
  int unsigned           lim_seen;
  logic                  gaps_seen;
  logic                  stalls_seen;
  int unsigned           stall_left;
  int unsigned           line_idx;

  core_frontend #(
    .reset_pc (reset_pc),
    .fb_depth (fb_depth)
  ) i_dut (
    .clock                  (clock),
    .reset                  (reset),
    .icache2core_data       (icache2core_data),
    .icache2core_data_valid (icache2core_data_valid),
    .core2icache_addr       (core2icache_addr),
    .backend_stall          (backend_stall),
    .uops                   (uops),
    .uops_valid             (uops_valid)
  );

  always #2 clock = ~clock;

  function automatic logic [inst_width-1:0] make_inst();
    logic [inst_width-1:0] word;
    int unsigned           kind;
    word = $urandom();
    kind = $urandom_range(0, 10);
    // low bits 2'b10 never match a legal opcode
    word[6:0] = (kind < 9) ? legal_opcodes[kind] : {word[6:2], 2'b10};
    if ($urandom_range(0, 3) == 0) begin
      word[11:7] = 5'd0;
    end
    return word;
  endfunction

  function automatic micro_op_t ref_decode(input addr_t pc, input logic [inst_width-1:0] inst);
    micro_op_t  exp;
    logic [6:0] opc;
    logic       no_dest;
    opc     = inst[6:0];
    exp.pc  = pc;
    exp.rd  = inst[11:7];
    exp.rs1 = inst[19:15];
    exp.rs2 = inst[24:20];
    if (opc == OPC_LOAD || opc == OPC_STORE) begin
      exp.uop_class = UOP_MEM;
    end else if (opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                             OPC_BRANCH, OPC_JAL, OPC_JALR}) begin
      exp.uop_class = UOP_INT;
    end else begin
      exp.uop_class = UOP_ILLEGAL;
    end
    no_dest = (opc == OPC_STORE) || (opc == OPC_BRANCH) ||
              (exp.uop_class == UOP_ILLEGAL) || (exp.rd == 5'd0);
    exp.rd_valid = !no_dest;
    return exp;
  endfunction

  task automatic check_uop(input micro_op_t got, input micro_op_t exp, input int slot);
    if (got !== exp) begin
      $display("[ERROR] uops[%0d] got %h expected %h", slot, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_valid(input logic [fetch_width-1:0] got,
                             input logic [fetch_width-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] uops_valid got %h expected %h", got, exp);
      value_errors++;
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] core2icache_addr got %h expected %h", got, exp);
      value_errors++;
    end
  endtask

  // expected micro-ops for the next lines, then let the cache serve them
  task automatic queue_lines(input int unsigned count);
    addr_t                 pc;
    logic [line_width-1:0] line;
    repeat (count) begin
      line = line_mem[next_line % mem_lines];
      for (int i = 0; i < fetch_width; i++) begin
        pc = reset_pc + 16 * next_line + 4 * i;
        expect_q.push_back(ref_decode(pc, line[i*inst_width +: inst_width]));
      end
      next_line++;
    end
    line_limit = next_line;
  endtask

  task automatic wait_queue(input int unsigned target, input int unsigned max_cycles);
    int unsigned waited;
    waited = 0;
    while (expect_q.size() > target && waited < max_cycles) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (expect_q.size() > target) begin
      $display("micro-op stream stopped with %0d micro-ops still expected", expect_q.size());
      stream_errors++;
    end
  endtask

  // icache model and back-end stall
  always @(posedge clock) begin
    lim_seen    = line_limit;
    gaps_seen   = gap_mode;
    stalls_seen = stall_mode;
    #1;
    line_idx = (core2icache_addr - reset_pc) >> 4;
    icache2core_data       = line_mem[line_idx % mem_lines];
    icache2core_data_valid = (line_idx < lim_seen) && (!gaps_seen || $urandom_range(0, 1) == 1);
    if (!stalls_seen) begin
      stall_left    = 0;
      backend_stall = 1'b0;
    end else if (stall_left > 0) begin
      stall_left--;
      backend_stall = 1'b1;
    end else if ($urandom_range(0, 3) == 0) begin
      stall_left    = $urandom_range(4, 11);
      backend_stall = 1'b1;
    end else begin
      backend_stall = 1'b0;
    end
  end

  // a group is taken on the edge after a valid, unstalled cycle
  always @(negedge clock) begin
    if (!reset && uops_valid != '0 && !backend_stall) begin
      check_valid(uops_valid, '1);
      if (expect_q.size() < fetch_width) begin
        $display("micro-op group at pc %h arrived with no group expected", uops[0].pc);
        stream_errors++;
      end else begin
        for (int i = 0; i < fetch_width; i++) begin
          check_uop(uops[i], expect_q.pop_front(), i);
        end
      end
    end
  end

  initial begin
    #(watchdog_time);
    $display("watchdog expired before the micro-op stream completed");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h0a6f5b42));
    clock                  = 1'b0;
    reset                  = 1'b1;
    icache2core_data       = '0;
    icache2core_data_valid = 1'b0;
    backend_stall          = 1'b0;
    value_errors           = 0;
    stream_errors          = 0;
    next_line              = 0;
    line_limit             = 0;
    gap_mode               = 1'b0;
    stall_mode             = 1'b0;
    stall_left             = 0;
    for (int n = 0; n < mem_lines; n++) begin
      for (int k = 0; k < fetch_width; k++) begin
        line_mem[n][k*inst_width +: inst_width] = make_inst();
      end
    end
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    check_addr(core2icache_addr, reset_pc);
    queue_lines(32);
    wait_queue(0, 32 * 12);
    gap_mode = 1'b1;
    queue_lines(24);
    wait_queue(0, 24 * 12);
    // stall runs outlast the buffer
    gap_mode   = 1'b0;
    stall_mode = 1'b1;
    queue_lines(24);
    wait_queue(0, 24 * 12);
    stall_mode = 1'b0;
    queue_lines(20);
    wait_queue(40, 20 * 12);
    @(posedge clock);
    #1;
    reset = 1'b1;
    @(posedge clock);
    #1;
    expect_q.delete();
    next_line  = 0;
    line_limit = 0;
    check_valid(uops_valid, '0);
    check_addr(core2icache_addr, reset_pc);
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    queue_lines(16);
    wait_queue(0, 16 * 12);
    repeat (10) @(posedge clock);
    if (expect_q.size() != 0) begin
      $display("run ended with %0d expected micro-ops never produced", expect_q.size());
      stream_errors++;
    end
    $display("errors: %0d value, %0d stream, %0d assertion",
             value_errors, stream_errors, i_dut.i_asserts.failures);
    if (value_errors == 0 && stream_errors == 0 && i_dut.i_asserts.failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* test/core_frontend_asserts.sv */
// ----------------------------------------------------------
// front end assertions
// fetch alignment, reset clearing and output hold under stall
// ----------------------------------------------------------

module core_frontend_asserts (
  input logic                              clock,
  input logic                              reset,
  input fetch_pkg::addr_t                  core2icache_addr,
  input logic                              backend_stall,
  input uop_pkg::uop_group_t               uops,
  input logic [fetch_pkg::fetch_width-1:0] uops_valid
);

  int unsigned failures = 0;

  addr_aligned: assert property (@(posedge clock) disable iff (reset)
    core2icache_addr[3:0] == 4'h0)
  else begin
    failures++;
    $error("fetch address %h is not line aligned", core2icache_addr);
  end

  // reset clears the output valid mask
  valid_after_reset: assert property (@(posedge clock)
    reset |=> uops_valid == '0)
  else begin
    failures++;
    $error("uops_valid is %h in the cycle after reset", uops_valid);
  end

  stall_hold: assert property (@(posedge clock) disable iff (reset)
    backend_stall |=> $stable(uops) && $stable(uops_valid))
  else begin
    failures++;
    $error("micro-op outputs changed while backend_stall was high");
  end

endmodule

bind core_frontend core_frontend_asserts i_asserts (
  .clock            (clock),
  .reset            (reset),
  .core2icache_addr (core2icache_addr),
  .backend_stall    (backend_stall),
  .uops             (uops),
  .uops_valid       (uops_valid)
);

/* source/core_frontend.sv */
// ----------------------------------------------------------
// core front end
// fetch, fetch buffer and decode from the icache port to
// the micro-op output
// ----------------------------------------------------------

module core_frontend #(
  parameter fetch_pkg::addr_t reset_pc = 32'h8000_0000,
  parameter int               fb_depth = 4
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [fetch_pkg::line_width-1:0]  icache2core_data,
  input  logic                              icache2core_data_valid,
  output fetch_pkg::addr_t                  core2icache_addr,
  input  logic                              backend_stall,
  output uop_pkg::uop_group_t               uops,
  output logic [fetch_pkg::fetch_width-1:0] uops_valid
);

  import fetch_pkg::*;

  fetch_group_t group;
  logic         group_valid;
  fetch_group_t head;
  logic         head_valid;
  logic         pop;
  logic         full;

  inst_fetch #(
    .reset_pc (reset_pc)
  ) i_fetch (
    .clock                  (clock),
    .reset                  (reset),
    .icache2core_data       (icache2core_data),
    .icache2core_data_valid (icache2core_data_valid),
    .full                   (full),
    .core2icache_addr       (core2icache_addr),
    .group                  (group),
    .group_valid            (group_valid)
  );

  fetch_buffer #(
    .fb_depth (fb_depth)
  ) i_buffer (
    .clock       (clock),
    .reset       (reset),
    .group       (group),
    .group_valid (group_valid),
    .pop         (pop),
    .head        (head),
    .head_valid  (head_valid),
    .full        (full)
  );

  inst_decode i_decode (
    .clock         (clock),
    .reset         (reset),
    .head          (head),
    .head_valid    (head_valid),
    .backend_stall (backend_stall),
    .pop           (pop),
    .uops          (uops),
    .uops_valid    (uops_valid)
  );

endmodule

/* source/inst_decode.sv */
// ----------------------------------------------------------
// instruction decode
// turns the buffer head into four registered micro-ops,
// held in place while the back end stalls
// ----------------------------------------------------------

module inst_decode (
  input  logic                                clock,
  input  logic                                reset,
  input  fetch_pkg::fetch_group_t             head,
  input  logic                                head_valid,
  input  logic                                backend_stall,
  output logic                                pop,
  output uop_pkg::uop_group_t                 uops,
  output logic [fetch_pkg::fetch_width-1:0]   uops_valid
);

  import fetch_pkg::*;
  import uop_pkg::*;

  uop_group_t next_uops;

  function automatic micro_op_t decode_one(input fetch_entry_t entry);
    micro_op_t uop;
    opcode_t   opcode;
    opcode  = entry.inst[6:0];
    uop.pc  = entry.pc;
    uop.rd  = entry.inst[11:7];
    uop.rs1 = entry.inst[19:15];
    uop.rs2 = entry.inst[24:20];
    case (opcode)
      OPC_LOAD, OPC_STORE: begin
        uop.uop_class = UOP_MEM;
      end
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
      OPC_BRANCH, OPC_JAL, OPC_JALR: begin
        uop.uop_class = UOP_INT;
      end
      default: begin
        uop.uop_class = UOP_ILLEGAL;
      end
    endcase
    // stores and branches have no destination
    uop.rd_valid = (uop.rd != '0) && (uop.uop_class != UOP_ILLEGAL) &&
                   (opcode != OPC_STORE) && (opcode != OPC_BRANCH);
    return uop;
  endfunction

  always_comb begin
    for (int i = 0; i < fetch_width; i++) begin
      next_uops[i] = decode_one(head[i]);
    end
  end

  // head leaves only when the output register loads
  assign pop = head_valid && !backend_stall;

  always_ff @(posedge clock) begin
    if (reset) begin
      uops_valid <= '0;
    end else if (!backend_stall) begin
      uops_valid <= {fetch_width{head_valid}};
    end
  end

  always_ff @(posedge clock) begin
    if (!backend_stall) begin
      uops <= next_uops;
    end
  end

endmodule

/* source/fetch_buffer.sv */
// ----------------------------------------------------------
// fetch buffer
// circular FIFO of fetch groups, head shown combinationally,
// full raised one slot early for the group in flight
// ----------------------------------------------------------

module fetch_buffer #(
  parameter int fb_depth = 4
) (
  input  logic                    clock,
  input  logic                    reset,
  input  fetch_pkg::fetch_group_t group,
  input  logic                    group_valid,
  input  logic                    pop,
  output fetch_pkg::fetch_group_t head,
  output logic                    head_valid,
  output logic                    full
);

  import fetch_pkg::*;

  localparam int ptr_w   = $clog2(fb_depth);
  localparam int count_w = $clog2(fb_depth + 1);

  typedef logic [ptr_w-1:0] ptr_t;

  fetch_group_t       mem [fb_depth];
  ptr_t               wr_ptr;
  ptr_t               rd_ptr;
  logic [count_w-1:0] count;
  logic               do_push;
  logic               do_pop;

  // depth need not be a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(fb_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = group_valid && (count != count_w'(fb_depth));
  assign do_pop  = pop && head_valid;

  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  // fewer than two free slots
  assign full = (count >= count_w'(fb_depth - 1));

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= group;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* source/inst_fetch.sv */
// ----------------------------------------------------------
// instruction fetch
// holds the pc, addresses the icache and captures each
// accepted line as one group of pc-tagged instructions
// ----------------------------------------------------------

module inst_fetch #(
  parameter fetch_pkg::addr_t reset_pc = 32'h8000_0000
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [fetch_pkg::line_width-1:0] icache2core_data,
  input  logic                             icache2core_data_valid,
  input  logic                             full,
  output fetch_pkg::addr_t                 core2icache_addr,
  output fetch_pkg::fetch_group_t          group,
  output logic                             group_valid
);

  import fetch_pkg::*;

  localparam addr_t line_bytes = addr_t'(line_width / 8);
  localparam int    inst_bytes = inst_width / 8;

  addr_t pc;
  logic  accept;

  // valid is ignored while the buffer is near full
  assign accept = icache2core_data_valid && !full;

  assign core2icache_addr = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (accept) begin
      pc <= pc + line_bytes;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      group_valid <= 1'b0;
    end else begin
      group_valid <= accept;
    end
  end

  // split the line, slot i sits at pc + 4*i
  always_ff @(posedge clock) begin
    if (accept) begin
      for (int i = 0; i < fetch_width; i++) begin
        group[i].pc   <= pc + addr_t'(i * inst_bytes);
        group[i].inst <= icache2core_data[i*inst_width +: inst_width];
      end
    end
  end

endmodule

/* source/uop_pkg.sv */
// ----------------------------------------------------------
// micro-op package
// register indices, opcodes, classes and the micro-op format
// ----------------------------------------------------------

package uop_pkg;

  typedef logic [4:0] arf_index_t;

  typedef logic [6:0] opcode_t;

  typedef enum logic [1:0] {
    UOP_INT     = 2'd0,
    UOP_MEM     = 2'd1,
    UOP_ILLEGAL = 2'd2
  } uop_class_t;

  // base integer opcodes
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  // control transfer
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;

  // 50 bits in all
  typedef struct packed {
    fetch_pkg::addr_t pc;
    uop_class_t       uop_class;
    arf_index_t       rd;
    arf_index_t       rs1;
    arf_index_t       rs2;
    logic             rd_valid;
  } micro_op_t;

  // one decoded fetch group, same slot order as the line
  typedef micro_op_t [fetch_pkg::fetch_width-1:0] uop_group_t;

endpackage

/* source/fetch_pkg.sv */
// ----------------------------------------------------------
// fetch package
// line geometry, byte addresses and fetch-entry types
// ----------------------------------------------------------

package fetch_pkg;

  // instructions per cache line
  localparam int fetch_width = 4;

  localparam int inst_width = 32;

  // one full icache line
  localparam int line_width = fetch_width * inst_width;

  typedef logic [31:0] addr_t;

  // one instruction tagged with its pc
  typedef struct packed {
    addr_t                 pc;
    logic [inst_width-1:0] inst;
  } fetch_entry_t;

  // slot 0 holds the lowest address
  typedef fetch_entry_t [fetch_width-1:0] fetch_group_t;

endpackage
